// File: bench/tb_tft_spi_ctrl.sv
`timescale 1ns/100ps

module tb_tft_spi_ctrl;
    import tft_mmio_pkg::*;

    localparam int ack_timeout = 200;

    logic clk;
    logic nrst;
    logic bus_req;
    logic bus_we;
    logic [bus_addr_w-1:0] bus_addr;
    logic [bus_data_w-1:0] bus_wdata;
    logic [bus_data_w-1:0] bus_rdata;
    logic bus_ack;
    logic chip_select;
    logic sclk;
    logic bit_data;
    logic miso;

    logic [7:0] reply_byte;
    integer seed;
    int rise_cnt;
    int pass_count;
    int fail_count;
    logic timed_out;
    logic [31:0] r;
    logic [31:0] word;
    int kind;

    tft_spi_ctrl tft_spi_ctrl_inst (
        .clk         (clk),
        .nrst        (nrst),
        .bus_req     (bus_req),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .bus_ack     (bus_ack),
        .chip_select (chip_select),
        .sclk        (sclk),
        .bit_data    (bit_data),
        .miso        (miso)
    );

    tft_spi_checker checker_inst (
        .clk         (clk),
        .nrst        (nrst),
        .bus_req     (bus_req),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .bus_rdata   (bus_rdata),
        .bus_ack     (bus_ack),
        .chip_select (chip_select),
        .sclk        (sclk),
        .bit_data    (bit_data),
        .miso        (miso),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ra8875 reply, second byte only, changes on falling sclk
    always @(posedge sclk) begin
        if (chip_select === 1'b0) begin
            rise_cnt = rise_cnt + 1;
        end
    end

    always @(posedge chip_select) begin
        rise_cnt = 0;
    end

    always @(negedge sclk) begin
        if (rise_cnt >= 8 && rise_cnt < 16) begin
            miso <= reply_byte[15 - rise_cnt];
        end
    end

    // one four-phase access, both edges of the handshake bounded
    task automatic bus_access(input logic we, input logic [bus_addr_w-1:0] addr,
                              input logic [31:0] wdata);
        int n;
        if (!timed_out) begin
            @(posedge clk);
            bus_req   <= 1'b1;
            bus_we    <= we;
            bus_addr  <= addr;
            bus_wdata <= wdata;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!bus_ack && n < ack_timeout);
            bus_req <= 1'b0;
            if (!bus_ack) begin
                $display("timeout: bus_ack did not rise within %0d cycles", ack_timeout);
                timed_out = 1'b1;
            end else begin
                n = 0;
                do begin
                    @(posedge clk);
                    n++;
                end while (bus_ack && n < ack_timeout);
                if (bus_ack) begin
                    $display("timeout: bus_ack did not fall after bus_req dropped");
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    initial begin
        seed       = 50517;
        nrst       = 1'b0;
        bus_req    = 1'b0;
        bus_we     = 1'b0;
        bus_addr   = '0;
        bus_wdata  = '0;
        miso       = 1'b0;
        reply_byte = 8'h00;
        rise_cnt   = 0;
        timed_out  = 1'b0;
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        bus_access(1'b0, addr_rdata, 32'h0);
        bus_access(1'b0, addr_cmd, 32'h0);
        for (int i = 0; i < 40 && !timed_out; i++) begin
            r = $random(seed);
            kind = int'(r[2:0]) % 5;
            reply_byte = r[15:8];
            r = $random(seed);
            case (kind)
                0, 1: begin
                    // about a quarter of frames are reads
                    word = {1'b0, 15'd0, (r[17:16] == 2'd0) ? 8'h40 : r[15:8], r[7:0]};
                    bus_access(1'b1, addr_cmd, word);
                    bus_access(1'b0, addr_rdata, 32'h0);
                end
                2: begin
                    word = {1'b1, 31'(1 + ({r} % 20))};
                    bus_access(1'b1, addr_cmd, word);
                    bus_access(1'b0, addr_cmd, 32'h0);
                end
                3: begin
                    bus_access(1'b1, addr_rdata, r);
                end
                default: begin
                    bus_access(1'b0, r[8] ? addr_cmd : addr_rdata, 32'h0);
                end
            endcase
        end
        bus_access(1'b0, addr_rdata, 32'h0);
        repeat (4) @(posedge clk);
        $display("tests passed %0d, tests failing %0d", pass_count, fail_count);
        if (timed_out || fail_count != 0) begin
            $display("tests failed");
        end else begin
            $display("all tests passed");
        end
        $finish;
    end

endmodule

// File: bench/tft_spi_checker.sv
`timescale 1ns/100ps

module tft_spi_checker (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                bus_req,
    input  logic                                bus_we,
    input  logic [tft_mmio_pkg::bus_addr_w-1:0] bus_addr,
    input  logic [tft_mmio_pkg::bus_data_w-1:0] bus_wdata,
    input  logic [tft_mmio_pkg::bus_data_w-1:0] bus_rdata,
    input  logic                                bus_ack,
    input  logic                                chip_select,
    input  logic                                sclk,
    input  logic                                bit_data,
    input  logic                                miso,
    output int                                  pass_count,
    output int                                  fail_count
);
    import tft_mmio_pkg::*;
    import tft_cmd_pkg::*;

    logic req_seen;
    logic ack_prev;
    logic req_prev;
    logic reset_checked;
    logic test_ok;
    int lat;
    int test_num;
    logic t_we;
    logic [bus_addr_w-1:0] t_addr;
    logic [31:0] t_wdata;
    logic [31:0] model_cmd;
    logic [31:0] model_rdata;
    logic [15:0] frame_cap;
    logic [miso_bits-1:0] miso_cap;
    int edge_cnt;
    logic cs_seen;

    initial begin
        pass_count    = 0;
        fail_count    = 0;
        reset_checked = 1'b0;
        req_seen      = 1'b0;
        test_num      = 0;
        model_cmd     = '0;
        model_rdata   = '0;
        cs_seen       = 1'b0;
        edge_cnt      = 0;
        frame_cap     = '0;
        miso_cap      = '0;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            test_ok = 1'b0;
        end
    endtask

    task automatic close_test(input string name);
        if (test_ok) begin
            $display("PASS %s", name);
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    // frame as the slave sees it
    always @(negedge chip_select) begin
        frame_cap = '0;
        miso_cap  = '0;
        edge_cnt  = 0;
        cs_seen   = 1'b1;
    end

    always @(posedge sclk) begin
        if (chip_select === 1'b0) begin
            // reply bits on the wire during the second byte
            if (edge_cnt >= frame_bits - miso_bits) begin
                miso_cap = {miso_cap[miso_bits-2:0], miso};
            end
            frame_cap = {frame_cap[14:0], bit_data};
            edge_cnt  = edge_cnt + 1;
        end
    end

    task automatic finish_access();
        string name;
        int n;
        test_ok = 1'b1;
        test_num++;
        if (!t_we) begin
            name = $sformatf("%s_%0d", (t_addr == addr_cmd) ? "read_cmd" : "read_rdata",
                             test_num);
            check_value(name, (t_addr == addr_cmd) ? model_cmd : model_rdata, bus_rdata);
            check_value({name, "_latency"}, 32'd2, 32'(lat));
        end else if (t_addr != addr_cmd) begin
            name = $sformatf("ignored_write_%0d", test_num);
            check_value({name, "_latency"}, 32'd2, 32'(lat));
        end else if (t_wdata[31]) begin
            name = $sformatf("delay_%0d", test_num);
            n = (t_wdata[30:0] == 31'd0) ? 1 : int'(t_wdata[30:0]);
            if (cs_seen) begin
                $display("chip_select went low during delay command in %s", name);
                test_ok = 1'b0;
            end
            if (lat < n) begin
                $display("FAIL %s expected at least %0d cycles actual %0d", name, n, lat);
                test_ok = 1'b0;
            end
            model_cmd = t_wdata;
        end else begin
            name = $sformatf("%s_%0d", (t_wdata[15:8] == ra8875_read_cmd) ? "spi_read"
                             : "spi_write", test_num);
            if (!cs_seen) begin
                $display("chip_select never went low for the frame in %s", name);
                test_ok = 1'b0;
            end
            check_value(name, {16'd0, t_wdata[15:0]}, {16'd0, frame_cap});
            check_value({name, "_edges"}, 32'(frame_bits), 32'(edge_cnt));
            if (t_wdata[15:8] == ra8875_read_cmd) begin
                model_rdata = {24'd0, miso_cap};
            end
            model_cmd = t_wdata;
        end
        close_test(name);
    endtask

    always @(posedge clk) begin
        if (!nrst) begin
            req_seen = 1'b0;
            ack_prev = 1'b0;
            req_prev = 1'b0;
        end else begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                test_ok = 1'b1;
                check_value("reset_idle", 32'hE, {28'd0, chip_select, sclk, bit_data, bus_ack});
                close_test("reset_idle");
            end
            if (bus_ack && !ack_prev && !bus_req) begin
                $display("bus_ack rose while bus_req was low");
                fail_count++;
            end
            if (!bus_ack && ack_prev && req_prev) begin
                $display("bus_ack fell while bus_req was still high");
                fail_count++;
            end
            if (bus_req && !req_seen && !bus_ack) begin
                req_seen = 1'b1;
                lat      = 0;
                t_we     = bus_we;
                t_addr   = bus_addr;
                t_wdata  = bus_wdata;
                cs_seen  = 1'b0;
            end else if (req_seen && !bus_ack) begin
                lat++;
            end
            if (req_seen && bus_ack && !ack_prev) begin
                finish_access();
                req_seen = 1'b0;
            end
            ack_prev = bus_ack;
            req_prev = bus_req;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the tft_spi_ctrl testbench with Verilator

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal \
    -f tft_spi_ctrl.f \
    --top-module tb_tft_spi_ctrl \
    -Mdir "$OBJ" -o tb_tft_spi_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/tb_tft_spi_ctrl" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi

exit 0

// File: tft_spi_ctrl.f
verilog/tft_mmio_pkg.sv
verilog/tft_cmd_pkg.sv
verilog/tft_mmio_regs.sv
verilog/tft_spi_engine.sv
verilog/tft_spi_ctrl.sv
bench/tft_spi_checker.sv
bench/tb_tft_spi_ctrl.sv

// File: verilog/tft_cmd_pkg.sv
package tft_cmd_pkg;

    // ra8875 frame is one command byte followed by one data byte
    localparam int frame_bits = 16;
    localparam int frame_cnt_w = $clog2(frame_bits);

    // reply bits clocked in during the second byte
    localparam int miso_bits = 8;

    // width of the cycle count in a delay word
    localparam int delay_w = 31;

    // command byte that returns data on miso
    localparam logic [7:0] ra8875_read_cmd = 8'h40;

    // bit 31 low, spi frame
    typedef struct packed {
        logic        delay_sel;
        logic [14:0] unused;
        logic [7:0]  cmd_byte;
        logic [7:0]  data_byte;
    } tft_spi_word_t;

    // bit 31 high, wait in clock cycles
    typedef struct packed {
        logic               delay_sel;
        logic [delay_w-1:0] cycles;
    } tft_delay_word_t;

    typedef union packed {
        tft_spi_word_t   spi_view;
        tft_delay_word_t delay_view;
    } tft_cmd_t;

endpackage

// File: verilog/tft_mmio_pkg.sv
package tft_mmio_pkg;

    // bus geometry of the register port
    localparam int bus_addr_w = 2;
    localparam int bus_data_w = 32;

    // register map
    // write issues a command word, read returns the last one
    localparam logic [bus_addr_w-1:0] addr_cmd = 2'd0;

    // read only, last miso byte zero extended
    localparam logic [bus_addr_w-1:0] addr_rdata = 2'd1;

endpackage

// File: verilog/tft_mmio_regs.sv
`timescale 1ns/100ps

module tft_mmio_regs (
    input  logic                                 clk,
    input  logic                                 nrst,
    input  logic                                 bus_req,
    input  logic                                 bus_we,
    input  logic [tft_mmio_pkg::bus_addr_w-1:0]  bus_addr,
    input  logic [tft_mmio_pkg::bus_data_w-1:0]  bus_wdata,
    output logic [tft_mmio_pkg::bus_data_w-1:0]  bus_rdata,
    output logic                                 bus_ack,
    output logic                                 cmd_req,
    output tft_cmd_pkg::tft_cmd_t                cmd_word,
    input  logic                                 cmd_ack,
    input  logic [tft_cmd_pkg::miso_bits-1:0]    rx_byte,
    input  logic                                 rx_valid
);
    import tft_mmio_pkg::*;
    import tft_cmd_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_respond,
        st_release
    } bus_state_t;

    bus_state_t state;
    logic [miso_bits-1:0] rx_data;
    logic cmd_write;

    assign cmd_write = bus_we && (bus_addr == addr_cmd);

    // read mux, held stable by the master while bus_ack is high
    always_comb begin
        case (bus_addr)
            addr_cmd: begin
                bus_rdata = cmd_word;
            end
            addr_rdata: begin
                bus_rdata = {{(bus_data_w - miso_bits){1'b0}}, rx_data};
            end
            default: begin
                bus_rdata = '0;
            end
        endcase
    end

    // bus slave fsm, command writes wait here for the engine
    always_ff @(posedge clk) begin
        if (!nrst) begin
            state    <= st_idle;
            bus_ack  <= 1'b0;
            cmd_req  <= 1'b0;
            cmd_word <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (bus_req) begin
                        if (cmd_write) begin
                            cmd_word <= bus_wdata;
                            cmd_req  <= 1'b1;
                        end
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    // reads and ignored writes pass straight through
                    if (!cmd_req) begin
                        state <= st_respond;
                    end else if (cmd_ack) begin
                        cmd_req <= 1'b0;
                        state   <= st_respond;
                    end
                end
                st_respond: begin
                    bus_ack <= 1'b1;
                    state   <= st_release;
                end
                st_release: begin
                    // hold ack until the master lets go
                    if (!bus_req) begin
                        bus_ack <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // last reply byte from the display
    always_ff @(posedge clk) begin
        if (!nrst) begin
            rx_data <= '0;
        end else if (rx_valid) begin
            rx_data <= rx_byte;
        end
    end

endmodule

// File: verilog/tft_spi_ctrl.sv
`timescale 1ns/100ps

module tft_spi_ctrl (
    input  logic                                clk,
    input  logic                                nrst,
    input  logic                                bus_req,
    input  logic                                bus_we,
    input  logic [tft_mmio_pkg::bus_addr_w-1:0] bus_addr,
    input  logic [tft_mmio_pkg::bus_data_w-1:0] bus_wdata,
    output logic [tft_mmio_pkg::bus_data_w-1:0] bus_rdata,
    output logic                                bus_ack,
    output logic                                chip_select,
    output logic                                sclk,
    output logic                                bit_data,
    input  logic                                miso
);
    import tft_cmd_pkg::*;

    // command hand-off between register block and engine
    logic cmd_req;
    logic cmd_ack;
    tft_cmd_t cmd_word;
    logic [miso_bits-1:0] rx_byte;
    logic rx_valid;

    tft_mmio_regs regs_inst (
        .clk       (clk),
        .nrst      (nrst),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .bus_ack   (bus_ack),
        .cmd_req   (cmd_req),
        .cmd_word  (cmd_word),
        .cmd_ack   (cmd_ack),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    tft_spi_engine engine_inst (
        .clk         (clk),
        .nrst        (nrst),
        .cmd_req     (cmd_req),
        .cmd_word    (cmd_word),
        .cmd_ack     (cmd_ack),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .chip_select (chip_select),
        .sclk        (sclk),
        .bit_data    (bit_data),
        .miso        (miso)
    );

endmodule

// File: verilog/tft_spi_engine.sv
`timescale 1ns/100ps

module tft_spi_engine (
    input  logic                              clk,
    input  logic                              nrst,
    input  logic                              cmd_req,
    input  tft_cmd_pkg::tft_cmd_t             cmd_word,
    output logic                              cmd_ack,
    output logic [tft_cmd_pkg::miso_bits-1:0] rx_byte,
    output logic                              rx_valid,
    output logic                              chip_select,
    output logic                              sclk,
    output logic                              bit_data,
    input  logic                              miso
);
    import tft_cmd_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_shift,
        st_delay,
        st_done
    } eng_state_t;

    eng_state_t state;
    logic [frame_cnt_w-1:0] bit_cnt;
    logic [delay_w-1:0] delay_cnt;
    logic read_flag;
    logic [frame_bits-1:0] frame;
    logic last_bit;
    logic capture;

    assign last_bit = (bit_cnt == frame_cnt_w'(frame_bits - 1));

    // sclk low now means it rises on this edge, the slave samples there too
    assign capture = (state == st_shift) && !sclk && read_flag
                     && (bit_cnt >= frame_cnt_w'(frame_bits - miso_bits));

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state       <= st_idle;
            cmd_ack     <= 1'b0;
            rx_valid    <= 1'b0;
            chip_select <= 1'b1;
            sclk        <= 1'b1;
            bit_data    <= 1'b1;
            read_flag   <= 1'b0;
            bit_cnt     <= '0;
            delay_cnt   <= '0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (cmd_req) begin
                        state <= st_load;
                    end
                end
                st_load: begin
                    // same word seen as a delay or as a spi frame
                    read_flag <= !cmd_word.spi_view.delay_sel
                                 && (cmd_word.spi_view.cmd_byte == ra8875_read_cmd);
                    bit_cnt   <= '0;
                    if (cmd_word.delay_view.delay_sel) begin
                        if (cmd_word.delay_view.cycles == '0) begin
                            delay_cnt <= delay_w'(1);
                        end else begin
                            delay_cnt <= cmd_word.delay_view.cycles;
                        end
                        state <= st_delay;
                    end else begin
                        chip_select <= 1'b0;
                        sclk        <= 1'b0;
                        bit_data    <= cmd_word.spi_view.cmd_byte[7];
                        state       <= st_shift;
                    end
                end
                st_shift: begin
                    if (!sclk) begin
                        sclk <= 1'b1;
                    end else if (last_bit) begin
                        // sclk already high, leave it there for idle
                        chip_select <= 1'b1;
                        bit_data    <= 1'b1;
                        rx_valid    <= read_flag;
                        cmd_ack     <= 1'b1;
                        state       <= st_done;
                    end else begin
                        sclk     <= 1'b0;
                        bit_data <= frame[frame_bits-2];
                        bit_cnt  <= bit_cnt + 1'b1;
                    end
                end
                st_delay: begin
                    if (delay_cnt == delay_w'(1)) begin
                        cmd_ack <= 1'b1;
                        state   <= st_done;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                st_done: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // frame shifter and miso capture
    always_ff @(posedge clk) begin
        if (state == st_load) begin
            frame <= {cmd_word.spi_view.cmd_byte, cmd_word.spi_view.data_byte};
        end else if (state == st_shift && sclk && !last_bit) begin
            frame <= {frame[frame_bits-2:0], 1'b0};
        end
        if (capture) begin
            rx_byte <= {rx_byte[miso_bits-2:0], miso};
        end
    end

endmodule
